//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_cpu
OBJ_DIR ?= obj_dir
FILELIST ?= src.f
VFLAGS ?= --binary --timing --assert -Wno-fatal
RUN_ARGS ?= +verilator+error+limit+100
PASS_MSG ?= >>> PASS

SIM := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard source/*.sv source/*.svh testbench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the pass line shows up in the simulation output
run: $(SIM)
	@out="$$($(SIM) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -x -F '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- source/alu.sv
`default_nettype none
`timescale 1ns/10ps

`include "cpu_consts.svh"

module alu (
	input core_pkg::word_t operand_a,
	input core_pkg::word_t operand_b,
	input isa_pkg::opcode_e opcode,
	input isa_pkg::alu_sub_e sub_op,
	output core_pkg::word_t result,
	output logic zero,
	output logic overflow
);

	logic do_sub;
	core_pkg::word_t addend;
	core_pkg::word_t b_eff;
	core_pkg::word_t sum;

	// lwi and swi offsets are in words
	always_comb begin
		do_sub = 1'b0;
		addend = operand_b;
		if (opcode == isa_pkg::opc_lwi || opcode == isa_pkg::opc_swi) begin
			addend = operand_b << 2;
		end
		if (opcode == isa_pkg::opc_beq) begin
			do_sub = 1'b1;
		end
		if (opcode == isa_pkg::opc_alu && sub_op == isa_pkg::sub_sub) begin
			do_sub = 1'b1;
		end
	end

	// one adder shared by add and subtract
	assign b_eff = do_sub ? ~addend : addend;
	assign sum = operand_a + b_eff + core_pkg::word_t'(do_sub);

	always_comb begin
		case (opcode)
			isa_pkg::opc_alu: begin
				case (sub_op)
					isa_pkg::sub_and: result = operand_a & operand_b;
					isa_pkg::sub_or: result = operand_a | operand_b;
					isa_pkg::sub_xor: result = operand_a ^ operand_b;
					default: result = sum;
				endcase
			end
			isa_pkg::opc_slli: result = operand_a << operand_b[4:0];
			default: result = sum;
		endcase
	end

	assign zero = (result == '0);

	// operands agree in sign but the sum does not
	assign overflow = (operand_a[`CPU_XLEN-1] == b_eff[`CPU_XLEN-1]) &&
		(sum[`CPU_XLEN-1] != operand_a[`CPU_XLEN-1]);

endmodule

`default_nettype wire

//--- source/controller.sv
`default_nettype none
`timescale 1ns/10ps

module controller (
	input logic enable_memaccess,
	input logic arst_n,
	input core_pkg::word_t instruction,
	input logic alu_zero,
	output logic enable_decode,
	output logic enable_execute,
	output logic enable_writeback,
	output logic im_read,
	output logic dm_read,
	output logic dm_write,
	output logic reg_write,
	output logic ovf_update,
	output isa_pkg::opcode_e opcode,
	output isa_pkg::alu_sub_e sub_op,
	output core_pkg::reg_idx_t ra_idx,
	output core_pkg::reg_idx_t rb_idx,
	output core_pkg::reg_idx_t rt_idx,
	output isa_pkg::imm15_t imm15,
	output isa_pkg::imm14_t imm14,
	output isa_pkg::imm24_t imm24,
	output isa_pkg::shamt_t shamt,
	output core_pkg::src2_sel_e src2_sel,
	output core_pkg::wb_sel_e wb_sel,
	output core_pkg::pc_sel_e pc_sel
);

	core_pkg::stage_e state;
	core_pkg::stage_e state_next;
	core_pkg::word_t ir;
	logic alu_sub_legal;

	always_comb begin
		case (state)
			core_pkg::stage_fetch: state_next = core_pkg::stage_decode;
			core_pkg::stage_decode: state_next = core_pkg::stage_execute;
			core_pkg::stage_execute: state_next = core_pkg::stage_memaccess;
			core_pkg::stage_memaccess: state_next = core_pkg::stage_writeback;
			default: state_next = core_pkg::stage_fetch;
		endcase
	end

	always_ff @(posedge enable_memaccess or negedge arst_n) begin
		if (!arst_n) begin
			state <= core_pkg::stage_fetch;
		end else begin
			state <= state_next;
		end
	end

	// zero decodes as a no-op until the first fetch completes
	always_ff @(posedge enable_memaccess or negedge arst_n) begin
		if (!arst_n) begin
			ir <= '0;
		end else if (state == core_pkg::stage_fetch) begin
			ir <= instruction;
		end
	end

	assign im_read = (state == core_pkg::stage_fetch);
	assign enable_decode = (state == core_pkg::stage_decode);
	assign enable_execute = (state == core_pkg::stage_execute);
	assign enable_writeback = (state == core_pkg::stage_writeback);

	// fields of the held instruction
	assign opcode = isa_pkg::opcode_e'(ir[30:25]);
	assign sub_op = isa_pkg::alu_sub_e'(ir[4:0]);
	assign rt_idx = ir[24:20];
	assign ra_idx = ir[19:15];
	assign imm15 = ir[14:0];
	assign imm14 = ir[13:0];
	assign imm24 = ir[23:0];
	assign shamt = ir[14:10];

	// beq reads rt through the rb port
	assign rb_idx = (opcode == isa_pkg::opc_beq) ? ir[24:20] : ir[14:10];

	assign alu_sub_legal = (sub_op == isa_pkg::sub_add) || (sub_op == isa_pkg::sub_sub) ||
		(sub_op == isa_pkg::sub_and) || (sub_op == isa_pkg::sub_or) ||
		(sub_op == isa_pkg::sub_xor);

	always_comb begin
		reg_write = 1'b0;
		ovf_update = 1'b0;
		src2_sel = core_pkg::src2_rb;
		wb_sel = core_pkg::wb_alu;
		case (opcode)
			isa_pkg::opc_alu: begin
				reg_write = alu_sub_legal;
				ovf_update = (sub_op == isa_pkg::sub_add) || (sub_op == isa_pkg::sub_sub);
			end
			isa_pkg::opc_addi: begin
				reg_write = 1'b1;
				ovf_update = 1'b1;
				src2_sel = core_pkg::src2_imm15;
			end
			isa_pkg::opc_slli: begin
				reg_write = 1'b1;
				src2_sel = core_pkg::src2_shamt;
			end
			isa_pkg::opc_lwi: begin
				reg_write = 1'b1;
				src2_sel = core_pkg::src2_imm15;
				wb_sel = core_pkg::wb_mem;
			end
			isa_pkg::opc_swi: src2_sel = core_pkg::src2_imm15;
			default: ;
		endcase
	end

	assign dm_read = (state == core_pkg::stage_memaccess) && (opcode == isa_pkg::opc_lwi);
	assign dm_write = (state == core_pkg::stage_memaccess) && (opcode == isa_pkg::opc_swi);

	// alu_zero is only meaningful during execute, when the pc loads
	always_comb begin
		if (opcode == isa_pkg::opc_j) begin
			pc_sel = core_pkg::pc_jump;
		end else if (opcode == isa_pkg::opc_beq && alu_zero) begin
			pc_sel = core_pkg::pc_branch;
		end else begin
			pc_sel = core_pkg::pc_plus1;
		end
	end

endmodule

`default_nettype wire

//--- source/core_pkg.sv
`default_nettype none

`include "cpu_consts.svh"

package core_pkg;

	typedef logic [`CPU_XLEN-1:0] word_t;
	typedef logic [`CPU_PC_W-1:0] pc_t;
	typedef logic [`CPU_DM_AW-1:0] dm_addr_t;
	typedef logic [`CPU_RA_W-1:0] reg_idx_t;

	// one state per instruction step
	typedef enum logic [2:0] {
		stage_fetch,
		stage_decode,
		stage_execute,
		stage_memaccess,
		stage_writeback
	} stage_e;

	// second alu operand
	typedef enum logic [1:0] {
		src2_rb,
		src2_imm15,
		src2_shamt
	} src2_sel_e;

	typedef enum logic {
		wb_alu,
		wb_mem
	} wb_sel_e;

	typedef enum logic [1:0] {
		pc_plus1,
		pc_branch,
		pc_jump
	} pc_sel_e;

endpackage

`default_nettype wire

//--- source/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// data word and register width
`define CPU_XLEN 32

// instruction memory is word addressed
`define CPU_PC_W 10

// data memory is byte addressed, word aligned accesses only
`define CPU_DM_AW 12

// register index, 32 architectural registers
`define CPU_RA_W 5

// fetch, decode, execute, memaccess, writeback
`define CPU_STEPS 5

`endif

//--- source/cpu_top.sv
`default_nettype none
`timescale 1ns/10ps

`include "cpu_consts.svh"

module cpu_top (
	input logic enable_memaccess,
	input logic arst_n,
	input core_pkg::word_t instruction,
	output logic alu_overflow,
	output logic im_read,
	output core_pkg::pc_t im_address,
	output logic dm_read,
	output logic dm_write,
	output core_pkg::dm_addr_t dm_address,
	output core_pkg::word_t dm_wdata,
	input core_pkg::word_t dm_rdata
);

	// stage strobes and decoded levels
	logic enable_decode;
	logic enable_execute;
	logic enable_writeback;
	logic reg_write;
	logic ovf_update;
	isa_pkg::opcode_e opcode;
	isa_pkg::alu_sub_e sub_op;
	core_pkg::reg_idx_t ra_idx;
	core_pkg::reg_idx_t rb_idx;
	core_pkg::reg_idx_t rt_idx;
	isa_pkg::imm15_t imm15;
	isa_pkg::imm14_t imm14;
	isa_pkg::imm24_t imm24;
	isa_pkg::shamt_t shamt;
	core_pkg::src2_sel_e src2_sel;
	core_pkg::wb_sel_e wb_sel;
	core_pkg::pc_sel_e pc_sel;

	// datapath
	core_pkg::word_t ra_data;
	core_pkg::word_t rb_data;
	core_pkg::word_t rt_data;
	core_pkg::word_t alu_src2;
	core_pkg::word_t alu_result;
	core_pkg::word_t alu_result_q;
	core_pkg::word_t write_data;
	logic alu_zero;
	logic alu_ovf;

	controller controller_i (
		.enable_memaccess(enable_memaccess),
		.arst_n(arst_n),
		.instruction(instruction),
		.alu_zero(alu_zero),
		.enable_decode(enable_decode),
		.enable_execute(enable_execute),
		.enable_writeback(enable_writeback),
		.im_read(im_read),
		.dm_read(dm_read),
		.dm_write(dm_write),
		.reg_write(reg_write),
		.ovf_update(ovf_update),
		.opcode(opcode),
		.sub_op(sub_op),
		.ra_idx(ra_idx),
		.rb_idx(rb_idx),
		.rt_idx(rt_idx),
		.imm15(imm15),
		.imm14(imm14),
		.imm24(imm24),
		.shamt(shamt),
		.src2_sel(src2_sel),
		.wb_sel(wb_sel),
		.pc_sel(pc_sel)
	);

	regfile regfile_i (
		.enable_memaccess(enable_memaccess),
		.arst_n(arst_n),
		.enable_decode(enable_decode),
		.enable_writeback(enable_writeback),
		.reg_write(reg_write),
		.ra_idx(ra_idx),
		.rb_idx(rb_idx),
		.rt_idx(rt_idx),
		.write_data(write_data),
		.ra_data(ra_data),
		.rb_data(rb_data),
		.rt_data(rt_data)
	);

	alu alu_i (
		.operand_a(ra_data),
		.operand_b(alu_src2),
		.opcode(opcode),
		.sub_op(sub_op),
		.result(alu_result),
		.zero(alu_zero),
		.overflow(alu_ovf)
	);

	datapath_mux datapath_mux_i (
		.enable_memaccess(enable_memaccess),
		.arst_n(arst_n),
		.enable_execute(enable_execute),
		.ovf_update(ovf_update),
		.dm_read(dm_read),
		.rb_data(rb_data),
		.imm15(imm15),
		.imm14(imm14),
		.imm24(imm24),
		.shamt(shamt),
		.alu_result(alu_result),
		.alu_overflow(alu_ovf),
		.mem_data(dm_rdata),
		.src2_sel(src2_sel),
		.wb_sel(wb_sel),
		.pc_sel(pc_sel),
		.alu_src2(alu_src2),
		.write_data(write_data),
		.alu_result_q(alu_result_q),
		.overflow_q(alu_overflow),
		.current_pc(im_address)
	);

	// byte address from the latched result, store data from rt
	assign dm_address = alu_result_q[`CPU_DM_AW-1:0];
	assign dm_wdata = rt_data;

endmodule

`default_nettype wire

//--- source/datapath_mux.sv
`default_nettype none
`timescale 1ns/10ps

`include "cpu_consts.svh"

module datapath_mux (
	input logic enable_memaccess,
	input logic arst_n,
	input logic enable_execute,
	input logic ovf_update,
	input logic dm_read,
	input core_pkg::word_t rb_data,
	input isa_pkg::imm15_t imm15,
	input isa_pkg::imm14_t imm14,
	input isa_pkg::imm24_t imm24,
	input isa_pkg::shamt_t shamt,
	input core_pkg::word_t alu_result,
	input logic alu_overflow,
	input core_pkg::word_t mem_data,
	input core_pkg::src2_sel_e src2_sel,
	input core_pkg::wb_sel_e wb_sel,
	input core_pkg::pc_sel_e pc_sel,
	output core_pkg::word_t alu_src2,
	output core_pkg::word_t write_data,
	output core_pkg::word_t alu_result_q,
	output logic overflow_q,
	output core_pkg::pc_t current_pc
);

	core_pkg::word_t imm15_ext;
	core_pkg::word_t shamt_ext;
	core_pkg::word_t mem_q;
	core_pkg::pc_t pc_next;

	assign imm15_ext = {{(`CPU_XLEN-$bits(imm15)){imm15[$bits(imm15)-1]}}, imm15};
	assign shamt_ext = {{(`CPU_XLEN-$bits(shamt)){1'b0}}, shamt};

	always_comb begin
		case (src2_sel)
			core_pkg::src2_imm15: alu_src2 = imm15_ext;
			core_pkg::src2_shamt: alu_src2 = shamt_ext;
			default: alu_src2 = rb_data;
		endcase
	end

	always_ff @(posedge enable_memaccess) begin
		if (enable_execute) begin
			alu_result_q <= alu_result;
		end
		if (dm_read) begin
			mem_q <= mem_data;
		end
	end

	// only add, sub and addi touch the flag
	always_ff @(posedge enable_memaccess or negedge arst_n) begin
		if (!arst_n) begin
			overflow_q <= 1'b0;
		end else if (enable_execute && ovf_update) begin
			overflow_q <= alu_overflow;
		end
	end

	assign write_data = (wb_sel == core_pkg::wb_mem) ? mem_q : alu_result_q;

	// offsets wrap modulo the instruction memory size
	always_comb begin
		case (pc_sel)
			core_pkg::pc_branch: pc_next = current_pc + imm14[`CPU_PC_W-1:0];
			core_pkg::pc_jump: pc_next = current_pc + imm24[`CPU_PC_W-1:0];
			default: pc_next = current_pc + 1'b1;
		endcase
	end

	always_ff @(posedge enable_memaccess or negedge arst_n) begin
		if (!arst_n) begin
			current_pc <= '0;
		end else if (enable_execute) begin
			current_pc <= pc_next;
		end
	end

endmodule

`default_nettype wire

//--- source/isa_pkg.sv
`default_nettype none

package isa_pkg;

	// major opcode, instruction bits 30:25
	typedef enum logic [5:0] {
		opc_lwi  = 6'b000010,
		opc_swi  = 6'b001010,
		opc_alu  = 6'b100000,
		opc_j    = 6'b100100,
		opc_beq  = 6'b100110,
		opc_addi = 6'b101000,
		opc_slli = 6'b101110
	} opcode_e;

	// sub-operation of opc_alu, instruction bits 4:0
	typedef enum logic [4:0] {
		sub_add = 5'b00000,
		sub_sub = 5'b00001,
		sub_and = 5'b00010,
		sub_xor = 5'b00011,
		sub_or  = 5'b00100
	} alu_sub_e;

	// addi, lwi, swi immediate, bits 14:0
	typedef logic signed [14:0] imm15_t;

	// beq word offset, bits 13:0
	typedef logic signed [13:0] imm14_t;

	// j word offset, bits 23:0
	typedef logic signed [23:0] imm24_t;

	// slli shift amount, bits 14:10
	typedef logic [4:0] shamt_t;

	// rt is bits 24:20, ra bits 19:15, rb bits 14:10
	// beq compares rt with ra, its offset overlaps the rb field

endpackage

`default_nettype wire

//--- source/regfile.sv
`default_nettype none
`timescale 1ns/10ps

`include "cpu_consts.svh"

module regfile (
	input logic enable_memaccess,
	input logic arst_n,
	input logic enable_decode,
	input logic enable_writeback,
	input logic reg_write,
	input core_pkg::reg_idx_t ra_idx,
	input core_pkg::reg_idx_t rb_idx,
	input core_pkg::reg_idx_t rt_idx,
	input core_pkg::word_t write_data,
	output core_pkg::word_t ra_data,
	output core_pkg::word_t rb_data,
	output core_pkg::word_t rt_data
);

	// r0 has no storage
	core_pkg::word_t regs [1:2**`CPU_RA_W-1];

	function automatic core_pkg::word_t read_reg(core_pkg::reg_idx_t idx);
		if (idx == '0) begin
			return '0;
		end
		return regs[idx];
	endfunction

	always_ff @(posedge enable_memaccess or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < 2**`CPU_RA_W; i++) begin
				regs[i] <= '0;
			end
		end else if (enable_writeback && reg_write && rt_idx != '0) begin
			regs[rt_idx] <= write_data;
		end
	end

	// operand latches, held through execute and memaccess
	always_ff @(posedge enable_memaccess) begin
		if (enable_decode) begin
			ra_data <= read_reg(ra_idx);
			rb_data <= read_reg(rb_idx);
			rt_data <= read_reg(rt_idx);
		end
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+source
source/isa_pkg.sv
source/core_pkg.sv
source/alu.sv
source/regfile.sv
source/controller.sv
source/datapath_mux.sv
source/cpu_top.sv
testbench/cpu_sva.sv
testbench/tb_cpu.sv

//--- testbench/cpu_sva.sv
`default_nettype none
`timescale 1ns/10ps

module cpu_sva (
	input logic enable_memaccess,
	input logic arst_n,
	input logic im_read,
	input logic dm_read,
	input logic dm_write
);

	int fail_count = 0;

	fetch_not_with_data: assert property (@(posedge enable_memaccess) disable iff (!arst_n)
		!(im_read && (dm_read || dm_write)))
	else begin
		$error("fetch strobe high together with a data strobe");
		fail_count++;
	end

	read_write_exclusive: assert property (@(posedge enable_memaccess) disable iff (!arst_n)
		!(dm_read && dm_write))
	else begin
		$error("dm_read and dm_write high together");
		fail_count++;
	end

	// one fetch, then decode, execute, memaccess, writeback
	fetch_every_five: assert property (@(posedge enable_memaccess) disable iff (!arst_n)
		im_read |=> !im_read ##1 !im_read ##1 !im_read ##1 !im_read ##1 im_read)
	else begin
		$error("fetch strobe not followed by four idle cycles and a new fetch");
		fail_count++;
	end

endmodule

bind cpu_top cpu_sva cpu_sva_i (
	.enable_memaccess(enable_memaccess),
	.arst_n(arst_n),
	.im_read(im_read),
	.dm_read(dm_read),
	.dm_write(dm_write)
);

`default_nettype wire

//--- testbench/tb_cpu.sv
`default_nettype none
`timescale 1ns/10ps

`include "cpu_consts.svh"

module tb_cpu;

	localparam int prog_len = 200;
	localparam int mem_phase = 3;
	localparam int max_cycles = prog_len * `CPU_STEPS + 50;
	localparam int kind_none = 0;
	localparam int kind_load = 1;
	localparam int kind_store = 2;

	// low before any process starts, so time zero has no clock edge
	logic enable_memaccess = 1'b0;
	logic arst_n;
	core_pkg::word_t instruction;
	logic alu_overflow;
	logic im_read;
	core_pkg::pc_t im_address;
	logic dm_read;
	logic dm_write;
	core_pkg::dm_addr_t dm_address;
	core_pkg::word_t dm_wdata;
	core_pkg::word_t dm_rdata;

	core_pkg::word_t imem [0:2**`CPU_PC_W-1];
	core_pkg::word_t dut_dmem [0:2**(`CPU_DM_AW-2)-1];
	core_pkg::word_t model_dmem [0:2**(`CPU_DM_AW-2)-1];
	core_pkg::word_t model_regs [0:2**`CPU_RA_W-1];
	core_pkg::pc_t model_pc;
	logic model_ovf;
	logic ovf_prev;
	int exp_kind;
	core_pkg::dm_addr_t exp_addr;
	core_pkg::word_t exp_data;
	logic exp_rd;
	logic exp_wr;
	logic exp_ovf;
	integer seed;
	int error_count;
	int fetch_count;
	int taken_count;
	int not_taken_count;
	int jump_count;
	int since_fetch;
	int final_hits;
	int cycles;
	logic seen_fetch;
	logic done;

	cpu_top cpu_top_i (
		.enable_memaccess(enable_memaccess),
		.arst_n(arst_n),
		.instruction(instruction),
		.alu_overflow(alu_overflow),
		.im_read(im_read),
		.im_address(im_address),
		.dm_read(dm_read),
		.dm_write(dm_write),
		.dm_address(dm_address),
		.dm_wdata(dm_wdata),
		.dm_rdata(dm_rdata)
	);

	// memories answer in the same cycle
	assign instruction = imem[im_address];
	assign dm_rdata = dut_dmem[dm_address[`CPU_DM_AW-1:2]];

	always #50 enable_memaccess = ~enable_memaccess;

	always @(posedge enable_memaccess) begin
		if (dm_write) begin
			dut_dmem[dm_address[`CPU_DM_AW-1:2]] <= dm_wdata;
		end
	end

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		$display("ERR %0t %s expected %h actual %h", $time, name, exp, got);
		error_count++;
	endtask

	function automatic core_pkg::word_t reg_value(input logic [4:0] idx);
		if (idx == 5'd0) begin
			return '0;
		end
		return model_regs[idx];
	endfunction

	// signed result outside the 32-bit range
	function automatic logic add_overflows(input core_pkg::word_t a, input core_pkg::word_t b,
		input logic subtract);
		longint sa;
		longint sb;
		longint s;
		sa = $signed(a);
		sb = $signed(b);
		s = subtract ? sa - sb : sa + sb;
		return s != longint'($signed(s[31:0]));
	endfunction

	task automatic gen_program();
		logic [31:0] r;
		logic [31:0] r2;
		logic [4:0] sub;
		logic [4:0] ra;
		int pick;
		int span;
		int off;
		for (int k = 0; k < 2**`CPU_PC_W; k++) begin
			imem[k] = core_pkg::word_t'(k);
		end
		for (int i = 0; i < prog_len - 1; i++) begin
			r = $random(seed);
			r2 = $random(seed);
			pick = int'(r2 % 100);
			ra = r[9:5];
			// forward offsets only, so the run always reaches the end
			span = prog_len - 1 - i;
			if (span > 8) begin
				span = 8;
			end
			off = 1 + int'(r2[31:16] % span);
			case (r2[15:8] % 5)
				0: sub = isa_pkg::sub_add;
				1: sub = isa_pkg::sub_sub;
				2: sub = isa_pkg::sub_and;
				3: sub = isa_pkg::sub_or;
				default: sub = isa_pkg::sub_xor;
			endcase
			if (pick < 30) begin
				imem[i] = {1'b0, isa_pkg::opc_alu, r[4:0], ra, r[14:10], 5'b0, sub};
			end else if (pick < 45) begin
				imem[i] = {1'b0, isa_pkg::opc_addi, r[4:0], ra, r[29:15]};
			end else if (pick < 55) begin
				imem[i] = {1'b0, isa_pkg::opc_slli, r[4:0], ra, r[14:10], 10'b0};
			end else if (pick < 67) begin
				imem[i] = {1'b0, isa_pkg::opc_lwi, r[4:0], ra, r[29:15]};
			end else if (pick < 82) begin
				imem[i] = {1'b0, isa_pkg::opc_swi, r[4:0], ra, r[29:15]};
			end else if (pick < 94) begin
				// half of the branches compare a register with itself
				if (r[30]) begin
					ra = r[4:0];
				end
				imem[i] = {1'b0, isa_pkg::opc_beq, r[4:0], ra, 1'b0, 14'(off)};
			end else begin
				imem[i] = {1'b0, isa_pkg::opc_j, 1'b0, 24'(off)};
			end
		end
		imem[prog_len-1] = {1'b0, isa_pkg::opc_j, 25'b0};
	endtask

	task automatic preset_data();
		logic [31:0] r;
		for (int k = 0; k < 2**(`CPU_DM_AW-2); k++) begin
			r = $random(seed);
			dut_dmem[k] = r;
			model_dmem[k] = r;
		end
	endtask

	task automatic step_model(input core_pkg::word_t ins);
		logic [5:0] opc;
		logic [4:0] rt;
		core_pkg::word_t a;
		core_pkg::word_t b;
		core_pkg::word_t t;
		core_pkg::word_t imm;
		core_pkg::word_t res;
		core_pkg::word_t addr;
		logic wr;
		opc = ins[30:25];
		rt = ins[24:20];
		a = reg_value(ins[19:15]);
		b = reg_value(ins[14:10]);
		t = reg_value(rt);
		imm = {{17{ins[14]}}, ins[14:0]};
		addr = a + (imm << 2);
		wr = 1'b0;
		res = '0;
		exp_kind = kind_none;
		case (opc)
			isa_pkg::opc_alu: begin
				wr = 1'b1;
				case (ins[4:0])
					isa_pkg::sub_add: begin
						res = a + b;
						model_ovf = add_overflows(a, b, 1'b0);
					end
					isa_pkg::sub_sub: begin
						res = a - b;
						model_ovf = add_overflows(a, b, 1'b1);
					end
					isa_pkg::sub_and: res = a & b;
					isa_pkg::sub_or: res = a | b;
					isa_pkg::sub_xor: res = a ^ b;
					default: wr = 1'b0;
				endcase
			end
			isa_pkg::opc_addi: begin
				wr = 1'b1;
				res = a + imm;
				model_ovf = add_overflows(a, imm, 1'b0);
			end
			isa_pkg::opc_slli: begin
				wr = 1'b1;
				res = a << ins[14:10];
			end
			isa_pkg::opc_lwi: begin
				wr = 1'b1;
				res = model_dmem[addr[`CPU_DM_AW-1:2]];
				exp_kind = kind_load;
				exp_addr = addr[`CPU_DM_AW-1:0];
			end
			isa_pkg::opc_swi: begin
				model_dmem[addr[`CPU_DM_AW-1:2]] = t;
				exp_kind = kind_store;
				exp_addr = addr[`CPU_DM_AW-1:0];
				exp_data = t;
			end
			default: ;
		endcase
		if (wr && rt != 5'd0) begin
			model_regs[rt] = res;
		end
		if (opc == isa_pkg::opc_j) begin
			jump_count++;
			model_pc = core_pkg::pc_t'(int'(model_pc) + int'($signed(ins[23:0])));
		end else if (opc == isa_pkg::opc_beq && a == t) begin
			taken_count++;
			model_pc = core_pkg::pc_t'(int'(model_pc) + int'($signed(ins[13:0])));
		end else begin
			if (opc == isa_pkg::opc_beq) begin
				not_taken_count++;
			end
			model_pc = model_pc + 1'b1;
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge enable_memaccess) begin
		if (!arst_n) begin
			if (im_read !== 1'b1) report_mismatch("im_read", 1, im_read);
			if (im_address !== '0) report_mismatch("im_address", 0, im_address);
			if (dm_read !== 1'b0) report_mismatch("dm_read", 0, dm_read);
			if (dm_write !== 1'b0) report_mismatch("dm_write", 0, dm_write);
			if (alu_overflow !== 1'b0) report_mismatch("alu_overflow", 0, alu_overflow);
		end else if (!done) begin
			if (im_read) begin
				if (seen_fetch && since_fetch != `CPU_STEPS - 1) begin
					$display("fetch came %0d cycles after the previous one", since_fetch + 1);
					error_count++;
				end
				if (im_address !== model_pc) report_mismatch("im_address", model_pc, im_address);
				if (model_pc == core_pkg::pc_t'(prog_len - 1)) begin
					final_hits++;
				end
				if (final_hits == 2) begin
					done = 1'b1;
				end
				ovf_prev = model_ovf;
				step_model(imem[model_pc]);
				since_fetch = 0;
				seen_fetch = 1'b1;
				fetch_count++;
			end else begin
				since_fetch++;
				if (!seen_fetch) begin
					$display("no instruction fetch in the first cycle after reset");
					error_count++;
				end else if (since_fetch > `CPU_STEPS - 1) begin
					$display("instruction fetch missing %0d cycles after the last one",
						since_fetch);
					error_count++;
				end
			end
			exp_rd = seen_fetch && since_fetch == mem_phase && exp_kind == kind_load;
			exp_wr = seen_fetch && since_fetch == mem_phase && exp_kind == kind_store;
			if (dm_read !== exp_rd) report_mismatch("dm_read", exp_rd, dm_read);
			if (dm_write !== exp_wr) report_mismatch("dm_write", exp_wr, dm_write);
			if ((exp_rd || exp_wr) && dm_address !== exp_addr) begin
				report_mismatch("dm_address", exp_addr, dm_address);
			end
			if (exp_wr && dm_wdata !== exp_data) report_mismatch("dm_wdata", exp_data, dm_wdata);
			// flag loads at the end of execute
			exp_ovf = (since_fetch >= mem_phase) ? model_ovf : ovf_prev;
			if (alu_overflow !== exp_ovf) report_mismatch("alu_overflow", exp_ovf, alu_overflow);
		end
	end

	initial begin
		arst_n = 1'b0;
		seed = 32'h5951_969b;
		error_count = 0;
		fetch_count = 0;
		taken_count = 0;
		not_taken_count = 0;
		jump_count = 0;
		since_fetch = 0;
		final_hits = 0;
		cycles = 0;
		seen_fetch = 1'b0;
		done = 1'b0;
		model_pc = '0;
		model_ovf = 1'b0;
		ovf_prev = 1'b0;
		exp_kind = kind_none;
		exp_addr = '0;
		exp_data = '0;
		for (int k = 0; k < 2**`CPU_RA_W; k++) begin
			model_regs[k] = '0;
		end
		gen_program();
		preset_data();
		repeat (2) @(posedge enable_memaccess);
		#1 arst_n = 1'b1;
		while (!done && cycles < max_cycles) begin
			@(posedge enable_memaccess);
			cycles++;
		end
		if (!done) begin
			$display("timeout after %0d cycles without reaching the final self-jump", cycles);
			error_count++;
		end
		if (taken_count == 0 || not_taken_count == 0 || jump_count == 0) begin
			$display("program never exercised a taken branch, an untaken branch or a jump");
			error_count++;
		end
		error_count = error_count + cpu_top_i.cpu_sva_i.fail_count;
		$display("fetches %0d, branches taken %0d, not taken %0d, jumps %0d, errors %0d",
			fetch_count, taken_count, not_taken_count, jump_count, error_count);
		if (error_count == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
